/* verilog/core_decode_pkg.sv */
package core_decode_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [3:0]  alu_op;
	typedef logic [11:0] op_field;  // insn[27:20] followed by insn[7:4]
	typedef logic [1:0]  shift_kind;
	typedef logic [11:0] imm12;
	typedef logic [1:0]  psr_mask;  // Bit 1 enables the flags field, bit 0 the control field
	typedef logic [3:0]  cond_code;

	// ####################################################################
	// Data-processing opcodes
	// ####################################################################

	localparam alu_op ALU_AND = 4'h0;
	localparam alu_op ALU_EOR = 4'h1;
	localparam alu_op ALU_SUB = 4'h2;
	localparam alu_op ALU_RSB = 4'h3;
	localparam alu_op ALU_ADD = 4'h4;
	localparam alu_op ALU_ADC = 4'h5;
	localparam alu_op ALU_SBC = 4'h6;
	localparam alu_op ALU_RSC = 4'h7;
	localparam alu_op ALU_TST = 4'h8;
	localparam alu_op ALU_TEQ = 4'h9;
	localparam alu_op ALU_CMP = 4'ha;
	localparam alu_op ALU_CMN = 4'hb;
	localparam alu_op ALU_ORR = 4'hc;
	localparam alu_op ALU_MOV = 4'hd;
	localparam alu_op ALU_BIC = 4'he;
	localparam alu_op ALU_MVN = 4'hf;

	localparam reg_num R14 = 4'd14;
	localparam reg_num R15 = 4'd15;

	// ####################################################################
	// Group patterns on the operation field, matched with casez
	// ####################################################################

	localparam op_field GROUP_B           = 12'b101?_????_????;
	localparam op_field GROUP_MUL         = 12'b0000_00??_1001;
	localparam op_field INSN_MRS          = 12'b0001_0?00_0000;
	localparam op_field GROUP_MSR         = 12'b00?1_0?10_????;
	localparam op_field GROUP_ALU         = 12'b00??_????_????;
	localparam op_field GROUP_LDST_SINGLE = 12'b01??_????_????;
	localparam op_field GROUP_LDST_MULT   = 12'b100?_????_????;

endpackage

/* verilog/core_decode_fetch.sv */
module core_decode_fetch (
	input  logic                 clk,
	input  logic                 rst_n,
	input  core_decode_pkg::word insn_in,
	input  logic                 insn_valid,
	input  logic                 stall,
	input  logic                 flush,
	output core_decode_pkg::word insn,
	output logic                 insn_held_valid
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			insn_held_valid <= 1'b0;
		end else if (flush) begin
			insn_held_valid <= 1'b0;
		end else if (!stall) begin
			insn_held_valid <= insn_valid;
		end
	end

	// Only an accepted strobe replaces the held word
	always_ff @(posedge clk) begin
		if (insn_valid && !stall)
			insn <= insn_in;
	end

endmodule

/* verilog/core_decode_data.sv */
module core_decode_data (
	input  core_decode_pkg::word       insn,
	output core_decode_pkg::alu_op     data_op,
	output core_decode_pkg::reg_num    data_rd,
	output core_decode_pkg::reg_num    data_rn,
	output logic                       data_uses_rn,
	output logic                       data_writeback,
	output logic                       data_update_flags,
	output logic                       data_restore_spsr,
	output logic                       data_conditional,
	output logic                       data_is_imm,
	output core_decode_pkg::reg_num    snd_r,
	output core_decode_pkg::imm12      snd_imm,
	output core_decode_pkg::shift_kind snd_shift_kind,
	output logic [4:0]                 snd_shift_imm,
	output logic                       snd_shift_by_reg,
	output logic                       snd_undefined,
	output core_decode_pkg::reg_num    mul_rd,
	output core_decode_pkg::reg_num    mul_rs,
	output core_decode_pkg::reg_num    mul_rm,
	output logic                       mul_update_flags,
	output core_decode_pkg::reg_num    mrs_rd,
	output logic                       mrs_spsr,
	output logic                       msr_spsr,
	output logic                       msr_is_imm,
	output core_decode_pkg::psr_mask   msr_fields
);
	import core_decode_pkg::*;

	assign data_op = insn[24:21];
	assign data_rn = insn[19:16];
	assign data_rd = insn[15:12];
	assign data_is_imm = insn[25];
	assign data_update_flags = insn[20];

	// Test and compare only set flags
	assign data_writeback = !(data_op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});
	assign data_uses_rn = !(data_op inside {ALU_MOV, ALU_MVN});
	assign data_restore_spsr = insn[20] && data_rd == R15;
	assign data_conditional = data_op inside {ALU_ADC, ALU_SBC, ALU_RSC};  // Reads carry

	// Shifter operand, both forms sliced at once
	assign snd_imm = insn[11:0];
	assign snd_r = insn[3:0];
	assign snd_shift_kind = insn[6:5];
	assign snd_shift_imm = insn[11:7];
	assign snd_shift_by_reg = insn[4];
	assign snd_undefined = !insn[25] && insn[4] && insn[7];  // Bit 7 must be clear here

	assign mul_rd = insn[19:16];
	assign mul_rs = insn[11:8];
	assign mul_rm = insn[3:0];
	assign mul_update_flags = insn[20];

	assign mrs_rd = insn[15:12];
	assign mrs_spsr = insn[22];
	assign msr_spsr = insn[22];
	assign msr_is_imm = insn[25];
	assign msr_fields = {insn[19], insn[16]};

endmodule

/* verilog/core_decode_ldst.sv */
module core_decode_ldst (
	input  core_decode_pkg::word    insn,
	output logic                    ldst_load,
	output logic                    ldst_writeback,
	output logic                    ldst_pre,
	output logic                    ldst_up,
	output logic                    ldst_byte,
	output core_decode_pkg::reg_num ldst_rn,
	output core_decode_pkg::reg_num ldst_rd,
	output logic                    ldst_single_is_imm,
	output logic                    ldst_mult_restore_spsr,
	output logic [15:0]             ldst_reglist
);
	import core_decode_pkg::*;

	assign ldst_pre = insn[24];
	assign ldst_up = insn[23];
	assign ldst_byte = insn[22];  // S bit on a multiple transfer
	assign ldst_load = insn[20];
	assign ldst_rn = insn[19:16];
	assign ldst_rd = insn[15:12];

	// Post-indexed single transfers always update the base
	assign ldst_writeback = insn[21] || (!insn[27] && !insn[24]);

	// Register offset when bit 25 is set, the reverse of data processing
	assign ldst_single_is_imm = !insn[25];

	assign ldst_reglist = insn[15:0];

	// LDM with S and the PC in the list returns from an exception
	assign ldst_mult_restore_spsr = insn[22] && insn[20] && ldst_reglist[R15];

endmodule

/* verilog/core_decode_mux.sv */
module core_decode_mux (
	input  core_decode_pkg::word       insn,
	input  core_decode_pkg::alu_op     data_op,
	input  core_decode_pkg::reg_num    data_rd, data_rn,
	input  logic                       data_uses_rn, data_writeback, data_update_flags,
	input  logic                       data_restore_spsr, data_conditional, data_is_imm,
	input  core_decode_pkg::reg_num    snd_r,
	input  core_decode_pkg::imm12      snd_imm,
	input  core_decode_pkg::shift_kind snd_shift_kind,
	input  logic [4:0]                 snd_shift_imm,
	input  logic                       snd_shift_by_reg, snd_undefined,
	input  core_decode_pkg::reg_num    mul_rd, mul_rs, mul_rm,
	input  logic                       mul_update_flags,
	input  core_decode_pkg::reg_num    mrs_rd,
	input  logic                       mrs_spsr, msr_spsr, msr_is_imm,
	input  core_decode_pkg::psr_mask   msr_fields,
	input  logic                       ldst_load, ldst_writeback, ldst_pre, ldst_up, ldst_byte,
	input  core_decode_pkg::reg_num    ldst_rn, ldst_rd,
	input  logic                       ldst_single_is_imm, ldst_mult_restore_spsr,
	input  logic [15:0]                ldst_reglist,
	output core_decode_pkg::cond_code  ctl_cond,
	output logic                       ctl_execute, ctl_undefined, ctl_branch, ctl_ldst, ctl_mul,
	output logic                       ctl_psr, ctl_writeback, ctl_conditional, ctl_update_flags,
	output logic                       ctl_restore_spsr, ctl_psr_write, ctl_psr_saved,
	output logic                       ctl_psr_wr_flags, ctl_psr_wr_control,
	output core_decode_pkg::alu_op     ctl_alu,
	output core_decode_pkg::reg_num    ctl_rd, ctl_rn,
	output logic                       ctl_uses_rn, ctl_snd_is_imm,
	output core_decode_pkg::imm12      ctl_snd_imm,
	output core_decode_pkg::reg_num    ctl_snd_r,
	output core_decode_pkg::shift_kind ctl_snd_shift_kind,
	output logic [4:0]                 ctl_snd_shift_imm,
	output logic                       ctl_snd_shift_by_reg, ctl_snd_ror_if_imm,
	output logic                       ctl_ldst_load, ctl_ldst_pre, ctl_ldst_up, ctl_ldst_byte,
	output logic [15:0]                ctl_ldst_reglist
);
	import core_decode_pkg::*;

	op_field op;

	assign op = {insn[27:20], insn[7:4]};
	assign ctl_cond = insn[31:28];

	always_comb begin
		ctl_execute = 1'b1;
		ctl_undefined = 1'b0;
		ctl_branch = 1'b0;
		ctl_ldst = 1'b0;
		ctl_mul = 1'b0;
		ctl_psr = 1'b0;
		ctl_writeback = 1'b0;
		ctl_conditional = 1'b0;
		ctl_update_flags = 1'b0;
		ctl_restore_spsr = 1'b0;
		ctl_psr_write = 1'b0;
		ctl_psr_saved = 1'b0;
		ctl_psr_wr_flags = 1'b0;
		ctl_psr_wr_control = 1'b0;
		ctl_alu = '0;
		ctl_rd = '0;
		ctl_rn = '0;
		ctl_uses_rn = 1'b1;
		ctl_snd_is_imm = 1'b1;
		ctl_snd_imm = '0;
		ctl_snd_r = '0;
		ctl_snd_shift_kind = '0;
		ctl_snd_shift_imm = '0;
		ctl_snd_shift_by_reg = 1'b0;
		ctl_snd_ror_if_imm = 1'b0;
		ctl_ldst_load = 1'b0;
		ctl_ldst_pre = 1'b0;
		ctl_ldst_up = 1'b0;
		ctl_ldst_byte = 1'b0;
		ctl_ldst_reglist = '0;

		// Order matters: multiply and PSR transfers hide inside the ALU space
		priority casez (op)
			GROUP_B: begin
				ctl_branch = 1'b1;
				ctl_uses_rn = insn[24];
				if (insn[24]) begin  // Link is lr = pc - 4
					ctl_alu = ALU_SUB;
					ctl_rd = R14;
					ctl_rn = R15;
					ctl_snd_imm = 12'd4;
					ctl_writeback = 1'b1;
				end
			end

			GROUP_MUL: begin
				ctl_mul = 1'b1;
				ctl_rd = mul_rd;
				ctl_rn = mul_rs;
				ctl_snd_is_imm = 1'b0;
				ctl_snd_r = mul_rm;
				ctl_writeback = 1'b1;
				ctl_update_flags = mul_update_flags;
			end

			INSN_MRS: begin
				ctl_psr = 1'b1;
				ctl_alu = ALU_MOV;
				ctl_rd = mrs_rd;
				ctl_uses_rn = 1'b0;
				ctl_psr_saved = mrs_spsr;
				ctl_writeback = 1'b1;
				ctl_conditional = 1'b1;
			end

			GROUP_MSR: begin
				ctl_psr = 1'b1;
				ctl_alu = ALU_MOV;
				ctl_uses_rn = 1'b0;
				ctl_snd_is_imm = msr_is_imm;
				ctl_snd_imm = snd_imm;
				ctl_snd_r = snd_r;
				ctl_snd_ror_if_imm = 1'b1;
				ctl_psr_write = 1'b1;
				ctl_psr_saved = msr_spsr;
				ctl_conditional = 1'b1;
				{ctl_psr_wr_flags, ctl_psr_wr_control} = msr_fields;
			end

			GROUP_ALU: begin
				ctl_alu = data_op;
				ctl_rd = data_rd;
				ctl_rn = data_rn;
				ctl_uses_rn = data_uses_rn;
				ctl_snd_is_imm = data_is_imm;
				ctl_snd_imm = snd_imm;
				ctl_snd_r = snd_r;
				ctl_snd_shift_kind = snd_shift_kind;
				ctl_snd_shift_imm = snd_shift_imm;
				ctl_snd_shift_by_reg = snd_shift_by_reg && !data_is_imm;
				ctl_snd_ror_if_imm = 1'b1;
				ctl_writeback = data_writeback;
				ctl_update_flags = data_update_flags;
				ctl_restore_spsr = data_restore_spsr;
				ctl_conditional = data_conditional;
				ctl_undefined = snd_undefined;
			end

			GROUP_LDST_SINGLE: begin
				ctl_ldst = 1'b1;
				ctl_rd = ldst_rd;
				ctl_rn = ldst_rn;
				ctl_snd_is_imm = ldst_single_is_imm;
				ctl_snd_imm = snd_imm;
				ctl_snd_r = snd_r;
				ctl_snd_shift_kind = snd_shift_kind;
				ctl_snd_shift_imm = snd_shift_imm;
				ctl_ldst_load = ldst_load;
				ctl_ldst_pre = ldst_pre;
				ctl_ldst_up = ldst_up;
				ctl_ldst_byte = ldst_byte;
				ctl_writeback = ldst_writeback || ldst_load;
				ctl_undefined = !ldst_single_is_imm && snd_shift_by_reg;  // No register shifts
			end

			GROUP_LDST_MULT: begin
				ctl_ldst = 1'b1;
				ctl_rn = ldst_rn;
				ctl_snd_imm = 12'd4;  // One word per listed register
				ctl_ldst_load = ldst_load;
				ctl_ldst_pre = ldst_pre;
				ctl_ldst_up = ldst_up;
				ctl_ldst_reglist = ldst_reglist;
				ctl_writeback = ldst_writeback || ldst_load;
				ctl_restore_spsr = ldst_mult_restore_spsr;
			end

			default:
				ctl_undefined = 1'b1;
		endcase

		if (ctl_undefined) begin
			ctl_execute = 1'b0;
			ctl_branch = 1'b0;
			ctl_ldst = 1'b0;
			ctl_mul = 1'b0;
			ctl_psr = 1'b0;
			ctl_writeback = 1'b0;
			ctl_psr_write = 1'b0;
			ctl_conditional = 1'b0;
			ctl_update_flags = 1'b0;
			ctl_restore_spsr = 1'b0;
		end
	end

endmodule

/* verilog/core_decode_issue.sv */
module core_decode_issue #(
	parameter bit STALL_RESET_VALID = 1'b1
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       stall,
	input  logic                       flush,
	input  logic                       in_valid,
	input  core_decode_pkg::cond_code  ctl_cond,
	input  logic                       ctl_execute, ctl_undefined, ctl_branch, ctl_ldst, ctl_mul,
	input  logic                       ctl_psr, ctl_writeback, ctl_conditional, ctl_update_flags,
	input  logic                       ctl_restore_spsr, ctl_psr_write, ctl_psr_saved,
	input  logic                       ctl_psr_wr_flags, ctl_psr_wr_control,
	input  core_decode_pkg::alu_op     ctl_alu,
	input  core_decode_pkg::reg_num    ctl_rd, ctl_rn,
	input  logic                       ctl_uses_rn, ctl_snd_is_imm,
	input  core_decode_pkg::imm12      ctl_snd_imm,
	input  core_decode_pkg::reg_num    ctl_snd_r,
	input  core_decode_pkg::shift_kind ctl_snd_shift_kind,
	input  logic [4:0]                 ctl_snd_shift_imm,
	input  logic                       ctl_snd_shift_by_reg, ctl_snd_ror_if_imm,
	input  logic                       ctl_ldst_load, ctl_ldst_pre, ctl_ldst_up, ctl_ldst_byte,
	input  logic [15:0]                ctl_ldst_reglist,
	output logic                       dec_valid,
	output core_decode_pkg::cond_code  cond,
	output logic                       execute, undefined, branch, ldst, mul,
	output logic                       psr, writeback, conditional, update_flags,
	output logic                       restore_spsr, psr_write, psr_saved,
	output logic                       psr_wr_flags, psr_wr_control,
	output core_decode_pkg::alu_op     alu,
	output core_decode_pkg::reg_num    rd, rn,
	output logic                       uses_rn, snd_is_imm,
	output core_decode_pkg::imm12      snd_imm,
	output core_decode_pkg::reg_num    snd_r,
	output core_decode_pkg::shift_kind snd_shift_kind,
	output logic [4:0]                 snd_shift_imm,
	output logic                       snd_shift_by_reg, snd_ror_if_imm,
	output logic                       ldst_load, ldst_pre, ldst_up, ldst_byte,
	output logic [15:0]                ldst_reglist
);

	localparam int CTL_W = 77;

	logic [CTL_W-1:0] ctl_d;
	logic [CTL_W-1:0] ctl_q;

	assign ctl_d = {ctl_cond, ctl_execute, ctl_undefined, ctl_branch, ctl_ldst, ctl_mul,
		ctl_psr, ctl_writeback, ctl_conditional, ctl_update_flags, ctl_restore_spsr,
		ctl_psr_write, ctl_psr_saved, ctl_psr_wr_flags, ctl_psr_wr_control,
		ctl_alu, ctl_rd, ctl_rn, ctl_uses_rn, ctl_snd_is_imm, ctl_snd_imm, ctl_snd_r,
		ctl_snd_shift_kind, ctl_snd_shift_imm, ctl_snd_shift_by_reg, ctl_snd_ror_if_imm,
		ctl_ldst_load, ctl_ldst_pre, ctl_ldst_up, ctl_ldst_byte, ctl_ldst_reglist};

	assign {cond, execute, undefined, branch, ldst, mul, psr, writeback, conditional,
		update_flags, restore_spsr, psr_write, psr_saved, psr_wr_flags, psr_wr_control,
		alu, rd, rn, uses_rn, snd_is_imm, snd_imm, snd_r, snd_shift_kind, snd_shift_imm,
		snd_shift_by_reg, snd_ror_if_imm, ldst_load, ldst_pre, ldst_up, ldst_byte,
		ldst_reglist} = ctl_q;

	// ####################################################################
	// With STALL_RESET_VALID clear, a stalled slot keeps its valid flag
	// until reset and a flush only takes effect once the stall lifts
	// ####################################################################

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			ctl_q <= '0;
		end else begin
			if (flush && (STALL_RESET_VALID || !stall))
				dec_valid <= 1'b0;
			else if (!stall)
				dec_valid <= in_valid;

			if (!stall && in_valid)
				ctl_q <= ctl_d;  // Fields stay put while no word arrives
		end
	end

endmodule

/* verilog/core_decode.sv */
module core_decode #(
	parameter bit STALL_RESET_VALID = 1'b1
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  core_decode_pkg::word       insn_in,
	input  logic                       insn_valid, stall, flush,
	output logic                       dec_valid,
	output core_decode_pkg::cond_code  cond,
	output logic                       execute, undefined, branch, ldst, mul,
	output logic                       psr, writeback, conditional, update_flags,
	output logic                       restore_spsr, psr_write, psr_saved,
	output logic                       psr_wr_flags, psr_wr_control,
	output core_decode_pkg::alu_op     alu,
	output core_decode_pkg::reg_num    rd, rn,
	output logic                       uses_rn, snd_is_imm,
	output core_decode_pkg::imm12      snd_imm,
	output core_decode_pkg::reg_num    snd_r,
	output core_decode_pkg::shift_kind snd_shift_kind,
	output logic [4:0]                 snd_shift_imm,
	output logic                       snd_shift_by_reg, snd_ror_if_imm,
	output logic                       ldst_load, ldst_pre, ldst_up, ldst_byte,
	output logic [15:0]                ldst_reglist
);
	import core_decode_pkg::*;

	word insn;
	logic insn_held_valid;

	// Decoder fields whose names clash with the registered outputs
	reg_num dp_snd_r;
	imm12 dp_snd_imm;
	shift_kind dp_snd_shift_kind;
	logic [4:0] dp_snd_shift_imm;
	logic dp_snd_shift_by_reg;
	logic ls_load, ls_pre, ls_up, ls_byte;
	logic [15:0] ls_reglist;

	alu_op data_op;
	reg_num data_rd, data_rn, mul_rd, mul_rs, mul_rm, mrs_rd, ldst_rn, ldst_rd;
	logic data_uses_rn, data_writeback, data_update_flags, data_restore_spsr;
	logic data_conditional, data_is_imm, snd_undefined, mul_update_flags;
	logic mrs_spsr, msr_spsr, msr_is_imm, ldst_writeback;
	logic ldst_single_is_imm, ldst_mult_restore_spsr;
	psr_mask msr_fields;

	// Unregistered control word
	cond_code ctl_cond;
	logic ctl_execute, ctl_undefined, ctl_branch, ctl_ldst, ctl_mul, ctl_psr;
	logic ctl_writeback, ctl_conditional, ctl_update_flags, ctl_restore_spsr;
	logic ctl_psr_write, ctl_psr_saved, ctl_psr_wr_flags, ctl_psr_wr_control;
	alu_op ctl_alu;
	reg_num ctl_rd, ctl_rn, ctl_snd_r;
	logic ctl_uses_rn, ctl_snd_is_imm, ctl_snd_shift_by_reg, ctl_snd_ror_if_imm;
	imm12 ctl_snd_imm;
	shift_kind ctl_snd_shift_kind;
	logic [4:0] ctl_snd_shift_imm;
	logic ctl_ldst_load, ctl_ldst_pre, ctl_ldst_up, ctl_ldst_byte;
	logic [15:0] ctl_ldst_reglist;

	core_decode_fetch u_fetch (.*);

	core_decode_data u_data (
		.snd_r(dp_snd_r), .snd_imm(dp_snd_imm), .snd_shift_kind(dp_snd_shift_kind),
		.snd_shift_imm(dp_snd_shift_imm), .snd_shift_by_reg(dp_snd_shift_by_reg), .*
	);

	core_decode_ldst u_ldst (
		.ldst_load(ls_load), .ldst_pre(ls_pre), .ldst_up(ls_up), .ldst_byte(ls_byte),
		.ldst_reglist(ls_reglist), .*
	);

	core_decode_mux u_mux (
		.snd_r(dp_snd_r), .snd_imm(dp_snd_imm), .snd_shift_kind(dp_snd_shift_kind),
		.snd_shift_imm(dp_snd_shift_imm), .snd_shift_by_reg(dp_snd_shift_by_reg),
		.ldst_load(ls_load), .ldst_pre(ls_pre), .ldst_up(ls_up), .ldst_byte(ls_byte),
		.ldst_reglist(ls_reglist), .*
	);

	core_decode_issue #(
		.STALL_RESET_VALID(STALL_RESET_VALID)
	) u_issue (
		.in_valid(insn_held_valid), .*
	);

endmodule

/* sim/core_decode_sva.sv */
module core_decode_sva (
	input logic clk,
	input logic rst_n,
	input logic insn_valid,
	input logic stall,
	input logic dec_valid,
	input logic execute,
	input logic undefined,
	input logic branch,
	input logic ldst,
	input logic mul,
	input logic psr,
	input logic writeback
);
	timeunit 1ns;
	timeprecision 100ps;

	// Upstream must hold its strobe back while the stage is stalled
	no_valid_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!(insn_valid && stall))
		else $error("insn_valid pulsed while stall was high");

	dec_valid_low_after_reset: assert property (@(posedge clk) !rst_n |=> !dec_valid)
		else $error("dec_valid high in the cycle after a reset edge");

	undefined_blocks_classes: assert property (@(posedge clk) disable iff (!rst_n)
		undefined |-> !execute && !branch && !ldst && !mul && !psr && !writeback)
		else $error("undefined instruction left execute or a class flag high");

endmodule

bind core_decode core_decode_sva u_sva (.*);

/* sim/core_decode_tb.sv */
module core_decode_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import core_decode_pkg::*;

	localparam bit STALL_RESET_VALID = 1'b1;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS = 6;
	localparam int MAX_TEST_CYCLES = 150;  // Longest test issues 48 words of 2 cycles
	localparam int WATCHDOG_NS = NUM_TESTS * MAX_TEST_CYCLES * CLK_PERIOD + 200;

	logic clk = 1'b0;
	logic rst_n;
	word insn_in;
	logic insn_valid, stall, flush;
	logic dec_valid;
	cond_code cond;
	logic execute, undefined, branch, ldst, mul, psr, writeback, conditional, update_flags;
	logic restore_spsr, psr_write, psr_saved, psr_wr_flags, psr_wr_control;
	alu_op alu;
	reg_num rd, rn, snd_r;
	logic uses_rn, snd_is_imm, snd_shift_by_reg, snd_ror_if_imm;
	imm12 snd_imm;
	shift_kind snd_shift_kind;
	logic [4:0] snd_shift_imm;
	logic ldst_load, ldst_pre, ldst_up, ldst_byte;
	logic [15:0] ldst_reglist;

	logic [31:0] rng_state = 32'd56530;
	int errors = 0;
	int tests_run = 0;

	core_decode #(.STALL_RESET_VALID(STALL_RESET_VALID)) uut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ####################################################################
	// Helpers
	// ####################################################################

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic logic [31:0] output_snapshot();
		return {5'b0, dec_valid, branch, writeback, alu, rd, rn, snd_imm};
	endfunction

	task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// Starts on a falling edge and returns on the falling edge after the word reaches issue
	task automatic send_insn(word w, logic undef);
		insn_in = w;
		insn_valid = 1'b1;
		@(posedge clk);
		@(negedge clk);
		insn_valid = 1'b0;
		@(posedge clk);
		@(negedge clk);
		compare_field("dec_valid", 32'(dec_valid), 32'd1);
		compare_field("cond", 32'(cond), 32'(w[31:28]));
		compare_field("execute", 32'(execute), 32'(!undef));
		compare_field("undefined", 32'(undefined), 32'(undef));
	endtask

	task automatic expect_classes_clear();
		compare_field("branch", 32'(branch), 32'd0);
		compare_field("ldst", 32'(ldst), 32'd0);
		compare_field("mul", 32'(mul), 32'd0);
		compare_field("psr", 32'(psr), 32'd0);
		compare_field("writeback", 32'(writeback), 32'd0);
	endtask

	task automatic end_test(string name, int start);
		tests_run++;
		if (errors == start)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - start);
	endtask

	// ####################################################################
	// Directed tests
	// ####################################################################

	task automatic test_data_proc();
		int start;
		int i;
		int form;
		logic [31:0] r;
		word w;
		logic [3:0] op;
		logic s;
		start = errors;
		for (i = 0; i < 48; i++) begin
			r = xorshift32();
			op = i[3:0];
			form = i / 16;  // 0 shift by immediate, 1 immediate, 2 shift by register
			s = (op[3:2] == 2'b10) ? 1'b1 : r[20];  // Test and compare always carry S
			if (form == 1)
				w = {r[31:28], 2'b00, 1'b1, op, s, r[19:0]};
			else if (form == 2)
				w = {r[31:28], 2'b00, 1'b0, op, s, r[19:8], 1'b0, r[6:5], 1'b1, r[3:0]};
			else
				w = {r[31:28], 2'b00, 1'b0, op, s, r[19:5], 1'b0, r[3:0]};
			send_insn(w, 1'b0);
			compare_field("alu", 32'(alu), 32'(op));
			compare_field("rd", 32'(rd), 32'(w[15:12]));
			compare_field("rn", 32'(rn), 32'(w[19:16]));
			compare_field("writeback", 32'(writeback), 32'(op[3:2] != 2'b10));
			compare_field("uses_rn", 32'(uses_rn), 32'(op != 4'hd && op != 4'hf));
			compare_field("update_flags", 32'(update_flags), 32'(s));
			// ADC, SBC and RSC read the carry
			compare_field("conditional", 32'(conditional), 32'(op >= 4'h5 && op <= 4'h7));
			compare_field("snd_ror_if_imm", 32'(snd_ror_if_imm), 32'd1);
			compare_field("snd_is_imm", 32'(snd_is_imm), 32'(form == 1));
			compare_field("snd_shift_by_reg", 32'(snd_shift_by_reg), 32'(form == 2));
			if (form == 1) begin
				compare_field("snd_imm", 32'(snd_imm), 32'(w[11:0]));
			end else begin
				compare_field("snd_r", 32'(snd_r), 32'(w[3:0]));
				compare_field("snd_shift_kind", 32'(snd_shift_kind), 32'(w[6:5]));
				if (form == 0)
					compare_field("snd_shift_imm", 32'(snd_shift_imm), 32'(w[11:7]));
			end
		end
		end_test("data processing", start);
	endtask

	task automatic test_branch();
		int start;
		int i;
		logic [31:0] r;
		word w;
		start = errors;
		for (i = 0; i < 8; i++) begin
			r = xorshift32();
			w = {r[31:28], 3'b101, i[0], r[23:0]};
			send_insn(w, 1'b0);
			compare_field("branch", 32'(branch), 32'd1);
			compare_field("writeback", 32'(writeback), 32'(i[0]));
			if (i[0]) begin  // Link writes pc - 4 to lr
				compare_field("alu", 32'(alu), 32'(ALU_SUB));
				compare_field("rd", 32'(rd), 32'(R14));
				compare_field("rn", 32'(rn), 32'(R15));
				compare_field("snd_imm", 32'(snd_imm), 32'd4);
			end
		end
		end_test("branch", start);
	endtask

	task automatic test_ldst_single();
		int start;
		int i;
		logic [31:0] r;
		word w;
		start = errors;
		for (i = 0; i < 16; i++) begin
			r = xorshift32();
			w = {r[31:28], 2'b01, r[25:5], r[25] ? 1'b0 : r[4], r[3:0]};
			send_insn(w, 1'b0);
			compare_field("ldst", 32'(ldst), 32'd1);
			compare_field("ldst_load", 32'(ldst_load), 32'(w[20]));
			compare_field("ldst_pre", 32'(ldst_pre), 32'(w[24]));
			compare_field("ldst_up", 32'(ldst_up), 32'(w[23]));
			compare_field("ldst_byte", 32'(ldst_byte), 32'(w[22]));
			compare_field("rn", 32'(rn), 32'(w[19:16]));
			compare_field("rd", 32'(rd), 32'(w[15:12]));
			compare_field("snd_is_imm", 32'(snd_is_imm), 32'(!w[25]));
			compare_field("writeback", 32'(writeback), 32'(w[20] || w[21] || !w[24]));
		end
		end_test("single load/store", start);
	endtask

	task automatic test_ldm_mul();
		int start;
		int i;
		logic [31:0] r;
		word w;
		start = errors;
		for (i = 0; i < 10; i++) begin
			r = xorshift32();
			w = {r[31:28], 3'b100, r[24:0]};
			if (i < 2) begin  // S with the PC in the list, once as a load and once as a store
				w[22] = 1'b1;
				w[20] = ~i[0];
				w[15] = 1'b1;
			end
			send_insn(w, 1'b0);
			compare_field("ldst", 32'(ldst), 32'd1);
			compare_field("ldst_reglist", 32'(ldst_reglist), 32'(w[15:0]));
			compare_field("snd_imm", 32'(snd_imm), 32'd4);
			compare_field("rn", 32'(rn), 32'(w[19:16]));
			compare_field("restore_spsr", 32'(restore_spsr), 32'(w[22] && w[20] && w[15]));
			compare_field("writeback", 32'(writeback), 32'(w[21] || w[20]));
		end
		for (i = 0; i < 6; i++) begin
			r = xorshift32();
			w = {r[31:28], 6'b000000, r[21:8], 4'b1001, r[3:0]};
			send_insn(w, 1'b0);
			compare_field("mul", 32'(mul), 32'd1);
			compare_field("rd", 32'(rd), 32'(w[19:16]));
			compare_field("rn", 32'(rn), 32'(w[11:8]));
			compare_field("snd_r", 32'(snd_r), 32'(w[3:0]));
			compare_field("snd_is_imm", 32'(snd_is_imm), 32'd0);
			compare_field("writeback", 32'(writeback), 32'd1);
			compare_field("update_flags", 32'(update_flags), 32'(w[20]));
		end
		end_test("load/store multiple and multiply", start);
	endtask

	task automatic test_psr();
		int start;
		int i;
		int kind;
		logic [31:0] r;
		word w;
		start = errors;
		for (i = 0; i < 12; i++) begin
			r = xorshift32();
			kind = i % 3;
			if (kind == 0)
				w = {r[31:28], 5'b00010, r[22], 2'b00, 4'hf, r[15:12], 12'h000};
			else if (kind == 1)
				w = {r[31:28], 5'b00010, r[22], 2'b10, r[19:16], 4'hf, 8'h00, r[3:0]};
			else
				w = {r[31:28], 5'b00110, r[22], 2'b10, r[19:16], 4'hf, r[11:0]};
			send_insn(w, 1'b0);
			compare_field("psr", 32'(psr), 32'd1);
			compare_field("psr_saved", 32'(psr_saved), 32'(w[22]));
			compare_field("psr_write", 32'(psr_write), 32'(kind != 0));
			compare_field("psr_wr_flags", 32'(psr_wr_flags), 32'(kind != 0 && w[19]));
			compare_field("psr_wr_control", 32'(psr_wr_control), 32'(kind != 0 && w[16]));
			if (kind == 0)
				compare_field("rd", 32'(rd), 32'(w[15:12]));
			else
				compare_field("snd_is_imm", 32'(snd_is_imm), 32'(w[25]));
		end
		end_test("MRS and MSR", start);
	endtask

	task automatic test_undef_timing();
		int start;
		int i;
		logic [31:0] r;
		logic [31:0] held;
		word w;
		start = errors;
		r = xorshift32();
		send_insn({4'he, 4'b1110, r[23:0]}, 1'b1);  // Coprocessor space
		expect_classes_clear();
		send_insn({4'he, 3'b000, 4'b0100, 1'b0, r[19:8], 4'b1011, r[3:0]}, 1'b1);
		expect_classes_clear();

		w = {4'he, 3'b101, 1'b1, r[23:0]};
		send_insn(w, 1'b0);
		held = output_snapshot();
		stall = 1'b1;
		for (i = 0; i < 5; i++) begin
			insn_in = xorshift32();  // No strobe, so the word must not be taken
			@(posedge clk);
			@(negedge clk);
			compare_field("outputs under stall", output_snapshot(), held);
		end
		stall = 1'b0;

		// Two words back to back fill fetch and issue, then a flush empties both
		insn_in = w;
		insn_valid = 1'b1;
		@(posedge clk);
		@(negedge clk);
		insn_in = {4'he, 3'b101, 1'b0, r[23:0]};
		@(posedge clk);
		@(negedge clk);
		compare_field("dec_valid", 32'(dec_valid), 32'd1);
		insn_in = w;
		flush = 1'b1;  // The word strobed with the flush is dropped as well
		@(posedge clk);
		@(negedge clk);
		insn_valid = 1'b0;
		flush = 1'b0;
		compare_field("dec_valid", 32'(dec_valid), 32'd0);
		@(posedge clk);
		@(negedge clk);
		compare_field("dec_valid", 32'(dec_valid), 32'd0);
		end_test("undefined, stall and flush", start);
	endtask

	initial begin
		rst_n = 1'b0;
		insn_in = '0;
		insn_valid = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_data_proc();
		test_branch();
		test_ldst_single();
		test_ldm_mul();
		test_psr();
		test_undef_timing();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* core_decode.f */
verilog/core_decode_pkg.sv
verilog/core_decode_fetch.sv
verilog/core_decode_data.sv
verilog/core_decode_ldst.sv
verilog/core_decode_mux.sv
verilog/core_decode_issue.sv
verilog/core_decode.sv
sim/core_decode_sva.sv
sim/core_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module core_decode_tb -Mdir obj_dir -o core_decode_sim \
	-f core_decode.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/core_decode_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1
